//--- verilog/core_pkg.sv
/*
 * Shared definitions for the small integer core
 * Data, register, ID and immediate widths
 * Opcode enum and the instruction, issue and writeback packets
 */

package core_pkg;

    //////////////////////////////////////////////////
    // Widths
    localparam int DATA_W = 16;
    localparam int REG_COUNT = 8;
    localparam int REG_ADDR_W = 3;
    localparam int ID_W = 3;
    localparam int IMM_W = 8;

    //////////////////////////////////////////////////
    // Opcodes
    // All arithmetic wraps modulo 2^DATA_W
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_XOR = 3'd4,
        OP_LI  = 3'd5,
        OP_MUL = 3'd6
    } op_e;

    //////////////////////////////////////////////////
    // Packets
    // Instruction as offered by the outside world
    typedef struct packed {
        op_e                   op;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [IMM_W-1:0]      imm;
    } instr_t;

    // Operands and tags sent to an execution unit
    typedef struct packed {
        logic [ID_W-1:0]       id;
        logic [REG_ADDR_W-1:0] rd;
        op_e                   op;
        logic [DATA_W-1:0]     a;
        logic [DATA_W-1:0]     b;
    } unit_issue_t;

    // One result on its way to the register file
    typedef struct packed {
        logic [ID_W-1:0]       id;
        logic [REG_ADDR_W-1:0] rd;
        logic [DATA_W-1:0]     data;
    } wb_packet_t;

endpackage

//--- verilog/register_file.sv
/*
 * Register file
 * Eight data registers, two combinational read ports,
 * one write port fed by writeback
 */

module register_file (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [core_pkg::REG_ADDR_W-1:0] rs1_addr,
    input  logic [core_pkg::REG_ADDR_W-1:0] rs2_addr,
    output logic [core_pkg::DATA_W-1:0]     rs1_data,
    output logic [core_pkg::DATA_W-1:0]     rs2_data,
    input  logic                            wb_valid,
    input  core_pkg::wb_packet_t            wb
);
    import core_pkg::*;

    logic [DATA_W-1:0] regs [REG_COUNT];

    // No bypass; a written value shows up the cycle after writeback
    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_valid) begin
            regs[wb.rd] <= wb.data;
        end
    end

    //////////////////////////////////////////////////
    // Assertions
    known_write_addr : assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid |-> !$isunknown(wb.rd));

endmodule

//--- verilog/decode_issue.sv
/*
 * Decode and issue stage
 * Pending-register hazard check, operand read, ID tagging
 * and dispatch to the ALU or the multiplier
 */

module decode_issue (
    input  logic                            clk,
    input  logic                            rst_n,
    input  core_pkg::instr_t                instr,
    input  logic                            instr_valid,
    output logic                            instr_ready,
    output logic [core_pkg::REG_ADDR_W-1:0] rs1_addr,
    output logic [core_pkg::REG_ADDR_W-1:0] rs2_addr,
    input  logic [core_pkg::DATA_W-1:0]     rs1_data,
    input  logic [core_pkg::DATA_W-1:0]     rs2_data,
    input  logic                            mul_busy,
    output logic                            alu_start,
    output logic                            mul_start,
    output core_pkg::unit_issue_t           alu_issue,
    output core_pkg::unit_issue_t           mul_issue,
    input  logic                            wb_valid,
    input  core_pkg::wb_packet_t            wb
);
    import core_pkg::*;

    logic [REG_COUNT-1:0] pending;
    logic [ID_W-1:0]      next_id;
    logic                 is_mul;
    logic                 uses_rs;
    logic                 src_hazard;
    logic                 dst_hazard;
    logic                 accept;
    unit_issue_t          issue_pkt;
    unit_issue_t          issue_q;

    //////////////////////////////////////////////////
    // Hazards and ready
    assign rs1_addr = instr.rs1;
    assign rs2_addr = instr.rs2;

    assign is_mul = (instr.op == OP_MUL);
    // LI has no register sources
    assign uses_rs = (instr.op != OP_LI);

    assign src_hazard = uses_rs && (pending[instr.rs1] || pending[instr.rs2]);
    assign dst_hazard = pending[instr.rd];

    assign instr_ready = !src_hazard && !dst_hazard && !(is_mul && mul_busy);
    assign accept = instr_valid && instr_ready;

    //////////////////////////////////////////////////
    // Issue packet
    always_comb begin
        issue_pkt.id = next_id;
        issue_pkt.rd = instr.rd;
        issue_pkt.op = instr.op;
        issue_pkt.a = rs1_data;
        issue_pkt.b = (instr.op == OP_LI) ? DATA_W'(instr.imm) : rs2_data;
    end

    // Units latch operands on their own start, so one register serves both
    always_ff @(posedge clk) begin
        if (accept) begin
            issue_q <= issue_pkt;
        end
    end

    assign alu_issue = issue_q;
    assign mul_issue = issue_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alu_start <= 1'b0;
            mul_start <= 1'b0;
            next_id <= '0;
        end else begin
            alu_start <= accept && !is_mul;
            mul_start <= accept && is_mul;
            if (accept) begin
                next_id <= next_id + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // Pending destinations
    // Writeback clears, issue sets; the rd check keeps them apart
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= '0;
        end else begin
            if (wb_valid) begin
                pending[wb.rd] <= 1'b0;
            end
            if (accept) begin
                pending[instr.rd] <= 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // Assertions
    one_unit_started : assert property (@(posedge clk) disable iff (!rst_n)
        !(alu_start && mul_start));

    // Every result retires a register that was issued and still in flight
    wb_was_pending : assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid |-> pending[wb.rd]);

endmodule

//--- verilog/alu_unit.sv
/*
 * Single-cycle ALU
 * Add, subtract, logic ops and load-immediate,
 * result registered together with its ID and destination
 */

module alu_unit (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  alu_start,
    input  core_pkg::unit_issue_t alu_issue,
    output logic                  alu_done,
    output core_pkg::wb_packet_t  alu_result
);
    import core_pkg::*;

    logic [DATA_W-1:0] result;

    always_comb begin
        case (alu_issue.op)
            OP_ADD: result = alu_issue.a + alu_issue.b;
            OP_SUB: result = alu_issue.a - alu_issue.b;
            OP_AND: result = alu_issue.a & alu_issue.b;
            OP_OR:  result = alu_issue.a | alu_issue.b;
            OP_XOR: result = alu_issue.a ^ alu_issue.b;
            // Immediate already zero-extended into b
            OP_LI:  result = alu_issue.b;
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (alu_start) begin
            alu_result.id <= alu_issue.id;
            alu_result.rd <= alu_issue.rd;
            alu_result.data <= result;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alu_done <= 1'b0;
        end else begin
            alu_done <= alu_start;
        end
    end

endmodule

//--- verilog/mul_unit.sv
/*
 * Iterative shift-add multiplier
 * One partial product per cycle for MUL_STEPS cycles,
 * result held with done until the queue acknowledges it
 */

module mul_unit #(
    parameter int MUL_STEPS = core_pkg::DATA_W
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  mul_start,
    input  core_pkg::unit_issue_t mul_issue,
    output logic                  mul_busy,
    output logic                  mul_done,
    output core_pkg::wb_packet_t  mul_result,
    input  logic                  mul_ack
);
    import core_pkg::*;

    localparam int CNT_W = (MUL_STEPS > 1) ? $clog2(MUL_STEPS) : 1;

    typedef enum logic [1:0] {
        IDLE,
        COMPUTE,
        DONE
    } state_e;

    state_e            state;
    logic [CNT_W-1:0]  step;
    logic [DATA_W-1:0] mcand;
    logic [DATA_W-1:0] mplier;
    logic [DATA_W-1:0] acc;
    logic [ID_W-1:0]   id_q;
    logic [REG_ADDR_W-1:0] rd_q;

    // Busy from the start cycle so issue cannot slip a second MUL in
    assign mul_busy = mul_start || (state != IDLE);
    assign mul_done = (state == DONE);

    assign mul_result.id = id_q;
    assign mul_result.rd = rd_q;
    assign mul_result.data = acc;

    //////////////////////////////////////////////////
    // Control
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            step <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (mul_start) begin
                        state <= COMPUTE;
                        step <= '0;
                    end
                end
                COMPUTE: begin
                    step <= step + 1'b1;
                    if (step == CNT_W'(MUL_STEPS - 1)) begin
                        state <= DONE;
                    end
                end
                DONE: begin
                    if (mul_ack) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Datapath
    always_ff @(posedge clk) begin
        if (state == IDLE && mul_start) begin
            mcand <= mul_issue.a;
            mplier <= mul_issue.b;
            acc <= '0;
            id_q <= mul_issue.id;
            rd_q <= mul_issue.rd;
        end else if (state == COMPUTE) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    //////////////////////////////////////////////////
    // Assertions
    no_start_while_busy : assert property (@(posedge clk) disable iff (!rst_n)
        mul_start |-> state == IDLE);

endmodule

//--- verilog/result_queue.sv
/*
 * Multiplier result queue
 * Circular FIFO of writeback packets, filled by the multiplier
 * and drained by writeback in cycles the ALU leaves free
 */

module result_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 mul_done,
    input  core_pkg::wb_packet_t mul_result,
    output logic                 mul_ack,
    output logic                 head_valid,
    output core_pkg::wb_packet_t head,
    input  logic                 pop
);
    import core_pkg::*;

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    wb_packet_t       mem [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;

    assign mul_ack = (count != CNT_W'(QUEUE_DEPTH));
    assign push = mul_done && mul_ack;
    assign head_valid = (count != '0);
    assign head = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= mul_result;
        end
    end

    // Pointers wrap at QUEUE_DEPTH, which need not be a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Assertions
    no_pop_when_empty : assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> head_valid);

endmodule

//--- verilog/writeback.sv
/*
 * Writeback select
 * ALU result first since it cannot stall, queued multiplier
 * results in the remaining cycles
 */

module writeback (
    input  logic                 alu_done,
    input  core_pkg::wb_packet_t alu_result,
    input  logic                 head_valid,
    input  core_pkg::wb_packet_t head,
    output logic                 pop,
    output logic                 wb_valid,
    output core_pkg::wb_packet_t wb
);

    //////////////////////////////////////////////////
    // Fixed priority
    assign pop = head_valid && !alu_done;
    assign wb_valid = alu_done || head_valid;
    assign wb = alu_done ? alu_result : head;

endmodule

//--- verilog/small_core.sv
/*
 * Top level of the small in-order integer core
 * Decode/issue, register file, ALU, multiplier,
 * result queue and writeback
 */

module small_core #(
    parameter int QUEUE_DEPTH = 4,
    parameter int MUL_STEPS = core_pkg::DATA_W
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  core_pkg::instr_t     instr,
    input  logic                 instr_valid,
    output logic                 instr_ready,
    output logic                 wb_valid,
    output core_pkg::wb_packet_t wb
);
    import core_pkg::*;

    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [DATA_W-1:0]     rs1_data;
    logic [DATA_W-1:0]     rs2_data;

    logic        alu_start;
    logic        mul_start;
    logic        mul_busy;
    unit_issue_t alu_issue;
    unit_issue_t mul_issue;

    logic       alu_done;
    wb_packet_t alu_result;
    logic       mul_done;
    logic       mul_ack;
    wb_packet_t mul_result;
    logic       head_valid;
    wb_packet_t head;
    logic       pop;

    //////////////////////////////////////////////////
    // Issue and operands
    decode_issue decode_issue_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (instr),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .mul_busy    (mul_busy),
        .alu_start   (alu_start),
        .mul_start   (mul_start),
        .alu_issue   (alu_issue),
        .mul_issue   (mul_issue),
        .wb_valid    (wb_valid),
        .wb          (wb)
    );

    register_file register_file_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb_valid (wb_valid),
        .wb       (wb)
    );

    //////////////////////////////////////////////////
    // Execution units
    alu_unit alu_unit_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .alu_start  (alu_start),
        .alu_issue  (alu_issue),
        .alu_done   (alu_done),
        .alu_result (alu_result)
    );

    mul_unit #(
        .MUL_STEPS (MUL_STEPS)
    ) mul_unit_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .mul_start  (mul_start),
        .mul_issue  (mul_issue),
        .mul_busy   (mul_busy),
        .mul_done   (mul_done),
        .mul_result (mul_result),
        .mul_ack    (mul_ack)
    );

    //////////////////////////////////////////////////
    // Result buffering and writeback
    result_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) result_queue_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .mul_done   (mul_done),
        .mul_result (mul_result),
        .mul_ack    (mul_ack),
        .head_valid (head_valid),
        .head       (head),
        .pop        (pop)
    );

    writeback writeback_inst (
        .alu_done   (alu_done),
        .alu_result (alu_result),
        .head_valid (head_valid),
        .head       (head),
        .pop        (pop),
        .wb_valid   (wb_valid),
        .wb         (wb)
    );

endmodule

//--- sim/small_core_tb.sv
/*
 * Testbench for the small integer core
 * Instruction stream and expected results come from the tests file,
 * writebacks are matched to their instructions by ID
 */

module small_core_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import core_pkg::*;

    localparam int HALF_PERIOD = 50;
    localparam int RESET_CYCLES = 8;
    localparam int ACCEPT_TIMEOUT = 200;
    localparam int DRAIN_TIMEOUT = 400;
    localparam int ID_COUNT = 1 << ID_W;
    localparam string TEST_FILE = "sim/small_core_tests.txt";

    logic       clk;
    logic       rst_n;
    instr_t     instr;
    logic       instr_valid;
    logic       instr_ready;
    logic       wb_valid;
    wb_packet_t wb;

    // Test table, one entry per instruction in file order
    string             test_name [$];
    instr_t            test_instr [$];
    logic [DATA_W-1:0] test_exp [$];

    // Instructions in flight, indexed by ID
    bit in_flight [ID_COUNT];
    int flight_test [ID_COUNT];

    int accepted;
    int retired;
    int value_errors;
    int other_errors;
    bit aborted;

    small_core small_core_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (instr),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .wb_valid    (wb_valid),
        .wb          (wb)
    );

    always #HALF_PERIOD clk = ~clk;

    //////////////////////////////////////////////////
    // Test file
    function automatic bit parse_op(input string mnem, output op_e op);
        bit ok;
        ok = 1'b1;
        op = OP_ADD;
        case (mnem)
            "add": op = OP_ADD;
            "sub": op = OP_SUB;
            "and": op = OP_AND;
            "or":  op = OP_OR;
            "xor": op = OP_XOR;
            "li":  op = OP_LI;
            "mul": op = OP_MUL;
            default: ok = 1'b0;
        endcase
        return ok;
    endfunction

    task automatic load_tests();
        int     fd;
        int     code;
        int     fields;
        int     rd;
        int     rs1;
        int     rs2;
        int     imm;
        int     expected;
        string  line;
        string  name;
        string  mnem;
        op_e    op;
        instr_t ins;
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the test file %s", TEST_FILE);
            other_errors++;
            aborted = 1'b1;
            return;
        end
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code == 0) begin
                break;
            end
            fields = $sscanf(line, "%s %s %d %d %d %h %h",
                             name, mnem, rd, rs1, rs2, imm, expected);
            // Blank and comment lines
            if (fields < 1 || name.substr(0, 0) == "#") begin
                continue;
            end
            if (fields != 7 || !parse_op(mnem, op)) begin
                $display("Malformed line in the test file: %s", line);
                other_errors++;
                continue;
            end
            ins.op = op;
            ins.rd = REG_ADDR_W'(rd);
            ins.rs1 = REG_ADDR_W'(rs1);
            ins.rs2 = REG_ADDR_W'(rs2);
            ins.imm = IMM_W'(imm);
            test_name.push_back(name);
            test_instr.push_back(ins);
            test_exp.push_back(DATA_W'(expected));
        end
        $fclose(fd);
        if (test_instr.size() == 0) begin
            $display("No instructions were loaded from the test file");
            other_errors++;
            aborted = 1'b1;
        end
    endtask

    //////////////////////////////////////////////////
    // Stimulus
    task automatic offer_instr(input int idx);
        int              cycles;
        bit              taken;
        logic [ID_W-1:0] id;
        cycles = 0;
        taken = 1'b0;
        instr = test_instr[idx];
        instr_valid = 1'b1;
        while (!taken && cycles < ACCEPT_TIMEOUT) begin
            // Ready is combinational, let it settle before the edge
            #1;
            taken = instr_ready;
            @(posedge clk);
            if (taken) begin
                // k-th accepted instruction carries ID k mod 8
                id = ID_W'(accepted % ID_COUNT);
                assert (!in_flight[id]) else begin
                    $display("ID %0d was reused while still in flight", id);
                    other_errors++;
                end
                in_flight[id] = 1'b1;
                flight_test[id] = idx;
                accepted++;
            end
            @(negedge clk);
            cycles++;
        end
        instr_valid = 1'b0;
        if (!taken) begin
            $display("Timeout waiting for instruction %s to be accepted", test_name[idx]);
            other_errors++;
            aborted = 1'b1;
        end
    endtask

    //////////////////////////////////////////////////
    // Writeback checks
    task automatic check_writeback(input wb_packet_t pkt);
        int idx;
        assert (accepted > 0) else begin
            $display("Writeback seen before any instruction was accepted");
            other_errors++;
        end
        assert (in_flight[pkt.id]) else begin
            $display("Writeback with ID %0d matches no instruction in flight", pkt.id);
            other_errors++;
        end
        if (in_flight[pkt.id]) begin
            idx = flight_test[pkt.id];
            assert (pkt.rd == test_instr[idx].rd) else begin
                $display("Error %s: rd expected %0d, actual %0d",
                         test_name[idx], test_instr[idx].rd, pkt.rd);
                value_errors++;
            end
            assert (pkt.data === test_exp[idx]) else begin
                $display("Error %s: data expected %h, actual %h",
                         test_name[idx], test_exp[idx], pkt.data);
                value_errors++;
            end
            in_flight[pkt.id] = 1'b0;
            retired++;
        end
    endtask

    // Outputs settle after the rising edge, so look mid-cycle
    always @(negedge clk) begin
        if (rst_n && wb_valid === 1'b1) begin
            check_writeback(wb);
        end
    end

    task automatic wait_for_drain();
        int cycles;
        cycles = 0;
        while (retired < accepted && cycles < DRAIN_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (retired < accepted) begin
            $display("Timeout waiting for %0d outstanding writebacks", accepted - retired);
            other_errors++;
        end
        // A duplicate writeback would still show up here
        repeat (20) @(negedge clk);
        for (int i = 0; i < ID_COUNT; i++) begin
            assert (!in_flight[i]) else begin
                $display("Instruction %s never wrote back", test_name[flight_test[i]]);
                other_errors++;
            end
        end
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        instr = '0;
        instr_valid = 1'b0;
        accepted = 0;
        retired = 0;
        value_errors = 0;
        other_errors = 0;
        aborted = 1'b0;
        load_tests();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        #1;
        assert (instr_ready === 1'b1) else begin
            $display("instr_ready is not high after reset");
            other_errors++;
        end
        @(negedge clk);
        for (int i = 0; i < test_instr.size() && !aborted; i++) begin
            offer_instr(i);
        end
        if (!aborted) begin
            wait_for_drain();
        end
        $display("%0d accepted, %0d written back, %0d value errors, %0d other errors",
                 accepted, retired, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- sim/small_core_tests.txt
# name op rd rs1 rs2 imm(hex) expected(hex)
# rs1 and rs2 are ignored for li, imm is ignored for every other op
li_r1     li   1 0 0 12 0012
li_r2     li   2 0 0 34 0034
add_r3    add  3 1 2 00 0046
sub_r4    sub  4 1 2 00 ffde
and_r5    and  5 3 4 00 0046
or_r6     or   6 1 2 00 0036
xor_r7    xor  7 4 3 00 ff98
mul_r0    mul  0 1 2 00 03a8
li_r1b    li   1 0 0 05 0005
add_dep   add  2 0 1 00 03ad
mul_sq    mul  3 2 2 00 82e9
mul_b0    mul  4 1 1 00 0019
li_b0     li   5 0 0 07 0007
mul_b1    mul  6 5 1 00 0023
add_b0    add  7 5 1 00 000c
mul_b2    mul  0 7 7 00 0090
xor_b0    xor  1 1 5 00 0002
mul_b3    mul  2 4 6 00 036b
sub_b0    sub  5 1 7 00 fff6
mul_b4    mul  3 3 5 00 e2e6
or_b0     or   7 0 1 00 0092
mul_b5    mul  4 2 7 00 f306
and_end   and  6 4 5 00 f306

//--- small_core.f
verilog/core_pkg.sv
verilog/register_file.sv
verilog/decode_issue.sv
verilog/alu_unit.sv
verilog/mul_unit.sv
verilog/result_queue.sv
verilog/writeback.sv
verilog/small_core.sv
sim/small_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the small_core testbench with Verilator, run it, and judge the log.
# Run from the project root.

LOG=sim_run.log

rm -f "$LOG"

verilator --binary --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module small_core_tb -f small_core.f -o small_core_sim > "$LOG" 2>&1 &&
./obj_dir/small_core_sim >> "$LOG" 2>&1 ||
echo "Build or simulation stopped early" >> "$LOG"

grep -qx "Finished with no errors" "$LOG" && echo "PASS" ||
{ echo "FAIL, see $LOG"; exit 1; }
